/* s3g_defs_pkg.sv */
`default_nettype none

package s3g_defs_pkg;

    // Bank and payload sizes
    localparam int NUM_OUT_REGS  = 8;
    localparam int NUM_IN_REGS   = 8;
    localparam int NUM_INTS      = 32;
    localparam int INT_HOLDOFF   = 64;   // Cycles between interrupt reports
    localparam int PAYLOAD_BYTES = 8;

    localparam int OUT_SEL_BITS  = $clog2(NUM_OUT_REGS);
    localparam int IN_SEL_BITS   = $clog2(NUM_IN_REGS);
    localparam int HOLDOFF_BITS  = $clog2(INT_HOLDOFF + 1);

    // Command bytes
    localparam logic [7:0] CMD_VERSION       = 8'd0;
    localparam logic [7:0] CMD_WRITE_OUT_REG = 8'd60;
    localparam logic [7:0] CMD_READ_IN_REG   = 8'd61;
    localparam logic [7:0] CMD_OUT_STBS      = 8'd62;
    localparam logic [7:0] CMD_CLEAR_INTS    = 8'd63;
    localparam logic [7:0] CMD_MASK_INTS     = 8'd64;

    // Response bytes
    localparam logic [7:0] RESP_OK        = 8'h81;
    localparam logic [7:0] RESP_ERROR     = 8'h80;
    localparam logic [7:0] RESP_UNKNOWN   = 8'h85;
    localparam logic [7:0] RESP_INTERRUPT = 8'h50;
    localparam logic [7:0] VERSION_LO     = 8'hBA;
    localparam logic [7:0] VERSION_HI     = 8'hCE;

    // Decoder FSM encoding
    localparam logic [2:0] DEC_IDLE         = 3'd0;
    localparam logic [2:0] DEC_READ_SELECT  = 3'd1;
    localparam logic [2:0] DEC_READ_CAPTURE = 3'd2;
    localparam logic [2:0] DEC_DELAY        = 3'd3;
    localparam logic [2:0] DEC_BUSY         = 3'd4;

    typedef logic [PAYLOAD_BYTES-1:0][7:0] payload_t;   // Byte 0 lowest

    typedef logic [31:0] reg_word_t;

    typedef reg_word_t [NUM_OUT_REGS-1:0] out_bank_t;
    typedef reg_word_t [NUM_IN_REGS-1:0]  in_bank_t;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_OK,
        KIND_ERROR,
        KIND_UNKNOWN,
        KIND_VERSION,
        KIND_READ_REG,
        KIND_INTERRUPT
    } resp_kind_t;

    // Payload bytes 3..7 with byte 3 in the low bits
    typedef union packed {
        struct packed {
            reg_word_t  data;   // Bytes 4..7
            logic [7:0] addr;   // Byte 3
        } reg_view;
        struct packed {
            logic [7:0] spare;  // Byte 7
            reg_word_t  mask;   // Bytes 3..6
        } mask_view;
    } cmd_args_t;

endpackage

`default_nettype wire

/* s3g_command_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module s3g_command_decoder (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   rx_packet_done,
    input  wire logic                   rx_packet_error,
    input  wire logic [7:0]             rx_payload_len,
    input  wire s3g_defs_pkg::payload_t rx_payload,
    input  wire logic                   tx_busy,
    input  wire logic                   int_request,
    output s3g_defs_pkg::resp_kind_t    resp_kind,
    output logic [7:0]                  hdr0,
    output logic [7:0]                  hdr1,
    output logic                        out_wr,
    output logic [7:0]                  out_addr,
    output s3g_defs_pkg::reg_word_t     out_data,
    output s3g_defs_pkg::reg_word_t     stb_pulse_mask,
    output logic                        in_sel_load,
    output logic [7:0]                  in_sel,
    output logic                        clear_wr,
    output logic                        mask_wr,
    output s3g_defs_pkg::reg_word_t     arg_mask,
    output logic                        int_grant
);
    import s3g_defs_pkg::*;

    logic [2:0] state;
    logic [2:0] next_state;
    logic [7:0] hdr0_q;
    logic [7:0] hdr1_q;
    cmd_args_t  args;

    assign args = rx_payload[7:3];

    // Argument fields qualified by the write strobes below
    assign out_addr = args.reg_view.addr;
    assign out_data = args.reg_view.data;
    assign in_sel   = args.reg_view.addr;
    assign arg_mask = args.mask_view.mask;

    // Single-cycle responses echo the live header
    assign hdr0 = (state == DEC_IDLE) ? rx_payload[0] : hdr0_q;
    assign hdr1 = (state == DEC_IDLE) ? rx_payload[1] : hdr1_q;

    always_comb
    begin
        next_state     = state;
        resp_kind      = KIND_NONE;
        out_wr         = 1'b0;
        stb_pulse_mask = '0;
        in_sel_load    = 1'b0;
        clear_wr       = 1'b0;
        mask_wr        = 1'b0;
        int_grant      = 1'b0;

        case (state)
            DEC_IDLE:
            begin
                if (rx_packet_done)
                begin
                    next_state = DEC_DELAY;
                    if (rx_payload_len == 8'd0)
                        resp_kind = KIND_OK;    // Empty packet
                    else
                    begin
                        case (rx_payload[2])
                            CMD_VERSION:
                                resp_kind = KIND_VERSION;
                            CMD_WRITE_OUT_REG:
                            begin
                                out_wr    = 1'b1;
                                resp_kind = KIND_OK;
                            end
                            CMD_READ_IN_REG:
                            begin
                                in_sel_load = 1'b1;
                                next_state  = DEC_READ_SELECT;
                            end
                            CMD_OUT_STBS:
                            begin
                                stb_pulse_mask = args.mask_view.mask;
                                resp_kind      = KIND_OK;
                            end
                            CMD_CLEAR_INTS:
                            begin
                                clear_wr  = 1'b1;
                                resp_kind = KIND_OK;
                            end
                            CMD_MASK_INTS:
                            begin
                                mask_wr   = 1'b1;
                                resp_kind = KIND_OK;
                            end
                            default:
                                resp_kind = KIND_UNKNOWN;
                        endcase
                    end
                end
                else if (rx_packet_error)
                begin
                    resp_kind  = KIND_ERROR;
                    next_state = DEC_DELAY;
                end
                else if (int_request)
                begin
                    int_grant  = 1'b1;
                    resp_kind  = KIND_INTERRUPT;
                    next_state = DEC_DELAY;
                end
            end
            DEC_READ_SELECT:
                next_state = DEC_READ_CAPTURE;
            DEC_READ_CAPTURE:
            begin
                resp_kind  = KIND_READ_REG;     // in_data settled last edge
                next_state = DEC_DELAY;
            end
            DEC_DELAY:
                next_state = DEC_BUSY;          // Give tx_busy time to rise
            DEC_BUSY:
            begin
                if (!tx_busy)
                    next_state = DEC_IDLE;
            end
            default:
                next_state = DEC_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= DEC_IDLE;
        else
            state <= next_state;
    end

    // Header kept for the delayed read response
    always_ff @(posedge clk)
    begin
        if (state == DEC_IDLE && rx_packet_done)
        begin
            hdr0_q <= rx_payload[0];
            hdr1_q <= rx_payload[1];
        end
    end

endmodule

`default_nettype wire

/* s3g_io_registers.sv */
`timescale 1ns/10ps
`default_nettype none

module s3g_io_registers (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    out_wr,
    input  wire logic [7:0]              out_addr,
    input  wire s3g_defs_pkg::reg_word_t out_data,
    input  wire s3g_defs_pkg::reg_word_t stb_pulse_mask,
    input  wire logic                    in_sel_load,
    input  wire logic [7:0]              in_sel,
    input  wire s3g_defs_pkg::in_bank_t  in_regs,
    output s3g_defs_pkg::out_bank_t      out_regs,
    output s3g_defs_pkg::reg_word_t      out_stbs,
    output s3g_defs_pkg::reg_word_t      in_data
);
    import s3g_defs_pkg::*;

    logic [7:0] in_sel_q;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            out_regs <= '0;
            out_stbs <= '0;
            in_sel_q <= '0;
        end
        else
        begin
            out_stbs <= stb_pulse_mask;     // High for one cycle only
            if (out_wr && out_addr < NUM_OUT_REGS)
                out_regs[out_addr[OUT_SEL_BITS-1:0]] <= out_data;
            if (in_sel_load)
                in_sel_q <= in_sel;
        end
    end

    // Registered read mux that returns zero for unused addresses
    always_ff @(posedge clk)
    begin
        if (in_sel_q < NUM_IN_REGS)
            in_data <= in_regs[in_sel_q[IN_SEL_BITS-1:0]];
        else
            in_data <= '0;
    end

endmodule

`default_nettype wire

/* s3g_interrupt_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module s3g_interrupt_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire s3g_defs_pkg::reg_word_t ints,
    input  wire logic                    clear_wr,
    input  wire logic                    mask_wr,
    input  wire s3g_defs_pkg::reg_word_t arg_mask,
    input  wire logic                    int_grant,
    output s3g_defs_pkg::reg_word_t      pending,
    output logic                         int_request
);
    import s3g_defs_pkg::*;

    logic [NUM_INTS-1:0]     mask;
    logic [NUM_INTS-1:0]     active;
    logic [HOLDOFF_BITS-1:0] timer;

    assign active      = pending & mask;
    assign int_request = (active != '0) && (timer == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending <= '0;
            mask    <= '1;
        end
        else
        begin
            // A line held high sets its bit again even while being cleared
            if (clear_wr)
                pending <= (pending & ~arg_mask) | ints;
            else
                pending <= pending | ints;
            if (mask_wr)
                mask <= arg_mask;
        end
    end

    // Holdoff between reports
    always_ff @(posedge clk)
    begin
        if (rst)
            timer <= '0;
        else if (clear_wr || mask_wr)
            timer <= '0;
        else if (int_grant)
            timer <= HOLDOFF_BITS'(INT_HOLDOFF);
        else if (timer != '0)
            timer <= timer - 1'b1;
    end

endmodule

`default_nettype wire

/* s3g_response_builder.sv */
`timescale 1ns/10ps
`default_nettype none

module s3g_response_builder (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire s3g_defs_pkg::resp_kind_t resp_kind,
    input  wire logic [7:0]               hdr0,
    input  wire logic [7:0]               hdr1,
    input  wire s3g_defs_pkg::reg_word_t  in_data,
    input  wire s3g_defs_pkg::reg_word_t  pending,
    output logic                          tx_packet_wr,
    output logic [7:0]                    tx_payload_len,
    output s3g_defs_pkg::payload_t        tx_payload
);
    import s3g_defs_pkg::*;

    logic [7:0] status_code;

    // Code byte of the short responses
    always_comb
    begin
        case (resp_kind)
            KIND_ERROR:   status_code = RESP_ERROR;
            KIND_UNKNOWN: status_code = RESP_UNKNOWN;
            default:      status_code = RESP_OK;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tx_packet_wr <= 1'b0;
        else
            tx_packet_wr <= (resp_kind != KIND_NONE);
    end

    always_ff @(posedge clk)
    begin
        tx_payload_len <= 8'd0;
        tx_payload     <= '0;

        case (resp_kind)
            KIND_OK, KIND_ERROR, KIND_UNKNOWN:
            begin
                tx_payload_len <= 8'd3;
                tx_payload[0]  <= hdr0;
                tx_payload[1]  <= hdr1;
                tx_payload[2]  <= status_code;
            end
            KIND_VERSION:
            begin
                tx_payload_len <= 8'd5;
                tx_payload[0]  <= hdr0;
                tx_payload[1]  <= hdr1;
                tx_payload[2]  <= RESP_OK;
                tx_payload[3]  <= VERSION_LO;
                tx_payload[4]  <= VERSION_HI;
            end
            KIND_READ_REG:
            begin
                tx_payload_len   <= 8'd7;
                tx_payload[0]    <= hdr0;
                tx_payload[1]    <= hdr1;
                tx_payload[2]    <= RESP_OK;
                tx_payload[6:3]  <= in_data;    // Low byte first
            end
            KIND_INTERRUPT:
            begin
                // Unsolicited report carries no header echo
                tx_payload_len   <= 8'd7;
                tx_payload[0]    <= 8'hFF;
                tx_payload[1]    <= 8'hFF;
                tx_payload[2]    <= RESP_INTERRUPT;
                tx_payload[6:3]  <= pending;
            end
            default:
            begin
                tx_payload_len <= 8'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* s3g_executor.sv */
`timescale 1ns/10ps
`default_nettype none

module s3g_executor (
    input  wire logic                    clk,
    input  wire logic                    rst,

    // Receiver side
    input  wire logic                    rx_packet_done,
    input  wire logic                    rx_packet_error,
    input  wire logic [7:0]              rx_payload_len,
    input  wire s3g_defs_pkg::payload_t  rx_payload,

    // Transmitter side
    input  wire logic                    tx_busy,
    output logic                         tx_packet_wr,
    output logic [7:0]                   tx_payload_len,
    output s3g_defs_pkg::payload_t       tx_payload,

    input  wire s3g_defs_pkg::reg_word_t ints,
    input  wire s3g_defs_pkg::in_bank_t  in_regs,
    output s3g_defs_pkg::out_bank_t      out_regs,
    output s3g_defs_pkg::reg_word_t      out_stbs
);
    import s3g_defs_pkg::*;

    resp_kind_t resp_kind;
    logic [7:0] hdr0;
    logic [7:0] hdr1;
    logic       out_wr;
    logic [7:0] out_addr;
    reg_word_t  out_data;
    reg_word_t  stb_pulse_mask;
    logic       in_sel_load;
    logic [7:0] in_sel;
    reg_word_t  in_data;
    logic       clear_wr;
    logic       mask_wr;
    reg_word_t  arg_mask;
    logic       int_grant;
    logic       int_request;
    reg_word_t  pending;

    s3g_command_decoder u_decoder (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_payload_len  (rx_payload_len),
        .rx_payload      (rx_payload),
        .tx_busy         (tx_busy),
        .int_request     (int_request),
        .resp_kind       (resp_kind),
        .hdr0            (hdr0),
        .hdr1            (hdr1),
        .out_wr          (out_wr),
        .out_addr        (out_addr),
        .out_data        (out_data),
        .stb_pulse_mask  (stb_pulse_mask),
        .in_sel_load     (in_sel_load),
        .in_sel          (in_sel),
        .clear_wr        (clear_wr),
        .mask_wr         (mask_wr),
        .arg_mask        (arg_mask),
        .int_grant       (int_grant)
    );

    s3g_io_registers u_io_regs (
        .clk            (clk),
        .rst            (rst),
        .out_wr         (out_wr),
        .out_addr       (out_addr),
        .out_data       (out_data),
        .stb_pulse_mask (stb_pulse_mask),
        .in_sel_load    (in_sel_load),
        .in_sel         (in_sel),
        .in_regs        (in_regs),
        .out_regs       (out_regs),
        .out_stbs       (out_stbs),
        .in_data        (in_data)
    );

    s3g_interrupt_ctrl u_int_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ints        (ints),
        .clear_wr    (clear_wr),
        .mask_wr     (mask_wr),
        .arg_mask    (arg_mask),
        .int_grant   (int_grant),
        .pending     (pending),
        .int_request (int_request)
    );

    s3g_response_builder u_builder (
        .clk            (clk),
        .rst            (rst),
        .resp_kind      (resp_kind),
        .hdr0           (hdr0),
        .hdr1           (hdr1),
        .in_data        (in_data),
        .pending        (pending),
        .tx_packet_wr   (tx_packet_wr),
        .tx_payload_len (tx_payload_len),
        .tx_payload     (tx_payload)
    );

endmodule

`default_nettype wire

/* tb_s3g_executor.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_s3g_executor;
    import s3g_defs_pkg::*;

    localparam int NUM_PACKETS    = 200;
    localparam int TIMEOUT_CYCLES = NUM_PACKETS * 20 + 8 * INT_HOLDOFF;

    logic       clk;
    logic       rst;
    logic       rx_packet_done;
    logic       rx_packet_error;
    logic [7:0] rx_payload_len;
    payload_t   rx_payload;
    logic       tx_busy;
    logic       tx_packet_wr;
    logic [7:0] tx_payload_len;
    payload_t   tx_payload;
    reg_word_t  ints;
    in_bank_t   in_regs;
    out_bank_t  out_regs;
    reg_word_t  out_stbs;

    // Reference model state
    out_bank_t  exp_out_regs;
    reg_word_t  exp_mask;
    reg_word_t  exp_pending;
    int         cycle_count = 0;
    int         busy_left;

    s3g_executor DUT (
        .clk             (clk),
        .rst             (rst),
        .rx_packet_done  (rx_packet_done),
        .rx_packet_error (rx_packet_error),
        .rx_payload_len  (rx_payload_len),
        .rx_payload      (rx_payload),
        .tx_busy         (tx_busy),
        .tx_packet_wr    (tx_packet_wr),
        .tx_payload_len  (tx_payload_len),
        .tx_payload      (tx_payload),
        .ints            (ints),
        .in_regs         (in_regs),
        .out_regs        (out_regs),
        .out_stbs        (out_stbs)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // Transmitter stays busy 0 to 5 cycles per packet
    initial
    begin
        tx_busy   = 1'b0;
        busy_left = 0;
        forever
        begin
            @(posedge clk);
            #2;
            if (tx_packet_wr)
                busy_left = $urandom_range(5, 0);
            else if (busy_left > 0)
                busy_left = busy_left - 1;
            tx_busy = (busy_left != 0);
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input reg_word_t exp, input reg_word_t act);
        if (act !== exp)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_packet(input string name, input logic [7:0] exp_len,
                                input payload_t exp_pl);
        if (tx_payload_len !== exp_len || tx_payload !== exp_pl)
            stop_run($sformatf(
                "mismatch %s: expected len %0d payload %h, actual len %0d payload %h",
                name, exp_len, exp_pl, tx_payload_len, tx_payload));
    endtask

    task automatic check_out_bank(input string name, input out_bank_t exp);
        if (out_regs !== exp)
            stop_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, out_regs));
    endtask

    // Header echo plus one code byte
    function automatic payload_t short_reply(input payload_t req, input logic [7:0] code);
        payload_t r;
        r    = '0;
        r[0] = req[0];
        r[1] = req[1];
        r[2] = code;
        return r;
    endfunction

    function automatic payload_t make_cmd(input logic [7:0] cmd, input cmd_args_t args);
        payload_t p;
        p      = {$urandom(), $urandom()};
        p[2]   = cmd;
        p[7:3] = args;
        return p;
    endfunction

    task automatic send_packet(input logic is_error, input logic [7:0] len, input payload_t pl);
        @(posedge clk);
        #2;
        rx_packet_done  = !is_error;
        rx_packet_error = is_error;
        rx_payload_len  = len;
        rx_payload      = pl;
        @(posedge clk);
        #2;
        rx_packet_done  = 1'b0;
        rx_packet_error = 1'b0;
    endtask

    task automatic wait_response(output int cycles);
        @(negedge clk);
        cycles = 1;
        while (!tx_packet_wr)
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
    endtask

    // Back to idle once the transmitter drops busy
    task automatic wait_idle;
        @(negedge clk);
        if (tx_packet_wr)
            stop_run("tx_packet_wr stayed high for more than one cycle");
        check_word("out_stbs after response", '0, out_stbs);
        while (tx_busy)
            @(negedge clk);
    endtask

    task automatic run_command(input string name, input logic is_error, input logic [7:0] len,
                               input payload_t pl, input int exp_latency,
                               input logic [7:0] exp_len, input payload_t exp_pl);
        int cycles;
        send_packet(is_error, len, pl);
        wait_response(cycles);
        if (cycles != exp_latency)
            stop_run($sformatf("mismatch %s latency: expected %0d, actual %0d",
                               name, exp_latency, cycles));
        check_packet(name, exp_len, exp_pl);
    endtask

    task automatic unknown_command(input logic [7:0] cmd);
        payload_t pl;
        pl    = {$urandom(), $urandom()};
        pl[2] = cmd;
        run_command("unknown command", 1'b0, 8'($urandom_range(8, 1)), pl, 1, 8'd3,
                    short_reply(pl, RESP_UNKNOWN));
        wait_idle();
    endtask

    task automatic int_command(input string name, input logic [7:0] cmd, input reg_word_t bits);
        cmd_args_t args;
        payload_t  pl;
        args.mask_view.mask  = bits;
        args.mask_view.spare = 8'($urandom());
        pl = make_cmd(cmd, args);
        run_command(name, 1'b0, 8'd7, pl, 1, 8'd3, short_reply(pl, RESP_OK));
        if (cmd == CMD_CLEAR_INTS)
            exp_pending = exp_pending & ~bits;
        else
            exp_mask = bits;
        wait_idle();
    endtask

    task automatic pulse_ints(input reg_word_t lines);
        @(posedge clk);
        #2;
        ints = lines;
        @(posedge clk);
        #2;
        ints        = '0;
        exp_pending = exp_pending | lines;
    endtask

    // Report expected only for unmasked pending bits
    task automatic check_interrupts(input string name);
        int       cycles;
        payload_t exp_pl;
        if ((exp_pending & exp_mask) != '0)
        begin
            exp_pl      = '0;
            exp_pl[0]   = 8'hFF;
            exp_pl[1]   = 8'hFF;
            exp_pl[2]   = RESP_INTERRUPT;
            exp_pl[6:3] = exp_pending;
            wait_response(cycles);
            check_packet(name, 8'd7, exp_pl);
            wait_idle();
        end
        else
        begin
            repeat (2 * INT_HOLDOFF)
            begin
                @(negedge clk);
                if (tx_packet_wr)
                    stop_run($sformatf("%s: an interrupt report arrived unexpectedly", name));
            end
        end
    endtask

    initial
    begin
        payload_t   pl;
        payload_t   exp_pl;
        cmd_args_t  args;
        logic [7:0] cmd;
        logic [7:0] addr;
        reg_word_t  word;

        void'($urandom(96771));
        clk             = 1'b0;
        rst             = 1'b1;
        rx_packet_done  = 1'b0;
        rx_packet_error = 1'b0;
        rx_payload_len  = '0;
        rx_payload      = '0;
        ints            = '0;
        in_regs         = '0;
        exp_out_regs    = '0;
        exp_mask        = '1;
        exp_pending     = '0;

        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        if (tx_packet_wr !== 1'b0)
            stop_run("tx_packet_wr is not low after reset");
        check_word("out_stbs after reset", '0, out_stbs);
        check_out_bank("out_regs after reset", exp_out_regs);

        args   = cmd_args_t'({$urandom(), 8'($urandom())});
        pl     = make_cmd(CMD_VERSION, args);
        exp_pl = short_reply(pl, RESP_OK);
        exp_pl[3] = VERSION_LO;
        exp_pl[4] = VERSION_HI;
        run_command("version", 1'b0, 8'd3, pl, 1, 8'd5, exp_pl);
        wait_idle();

        pl = {$urandom(), $urandom()};
        run_command("empty packet", 1'b0, 8'd0, pl, 1, 8'd3, short_reply(pl, RESP_OK));
        wait_idle();

        pl = {$urandom(), $urandom()};
        run_command("receive error", 1'b1, 8'd4, pl, 1, 8'd3, short_reply(pl, RESP_ERROR));
        wait_idle();

        unknown_command(8'd27);     // Extended version query has no handler
        unknown_command(8'd65);
        repeat (10)
        begin
            cmd = 8'($urandom_range(255, 0));
            while (cmd == CMD_VERSION || (cmd >= CMD_WRITE_OUT_REG && cmd <= CMD_MASK_INTS))
                cmd = 8'($urandom_range(255, 0));
            unknown_command(cmd);
        end

        repeat (60)
        begin
            addr = 8'($urandom_range(11, 0));
            word = $urandom();
            args.reg_view.addr = addr;
            args.reg_view.data = word;
            pl = make_cmd(CMD_WRITE_OUT_REG, args);
            if (int'(addr) < NUM_OUT_REGS)
                exp_out_regs[addr[2:0]] = word;
            run_command("write out reg", 1'b0, 8'd8, pl, 1, 8'd3, short_reply(pl, RESP_OK));
            check_out_bank("out_regs after write", exp_out_regs);
            wait_idle();
        end

        repeat (60)
        begin
            @(posedge clk);
            #2;
            for (int i = 0; i < NUM_IN_REGS; i++)
                in_regs[i] = $urandom();
            addr = 8'($urandom_range(11, 0));
            args.reg_view.addr = addr;
            args.reg_view.data = $urandom();
            pl   = make_cmd(CMD_READ_IN_REG, args);
            word = (int'(addr) < NUM_IN_REGS) ? in_regs[addr[2:0]] : '0;
            exp_pl = short_reply(pl, RESP_OK);
            exp_pl[6:3] = word;
            run_command("read in reg", 1'b0, 8'd4, pl, 3, 8'd7, exp_pl);
            wait_idle();
        end

        repeat (20)
        begin
            word = $urandom();
            args.mask_view.mask  = word;
            args.mask_view.spare = 8'($urandom());
            pl = make_cmd(CMD_OUT_STBS, args);
            run_command("output strobe", 1'b0, 8'd7, pl, 1, 8'd3, short_reply(pl, RESP_OK));
            check_word("out_stbs in response cycle", word, out_stbs);
            wait_idle();        // Also checks the strobe has dropped
        end

        repeat (4)
        begin
            pulse_ints($urandom() | 32'h1);
            check_interrupts("interrupt report");
            int_command("partial clear", CMD_CLEAR_INTS, $urandom());
            check_interrupts("report after partial clear");
            int_command("full clear", CMD_CLEAR_INTS, '1);
            check_interrupts("no report after clear");
        end

        int_command("mask all", CMD_MASK_INTS, '0);
        pulse_ints($urandom() | 32'h1);
        check_interrupts("no report while masked");
        int_command("unmask all", CMD_MASK_INTS, '1);
        check_interrupts("report after unmask");
        int_command("final clear", CMD_CLEAR_INTS, '1);
        check_interrupts("no report after final clear");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
s3g_defs_pkg.sv
s3g_command_decoder.sv
s3g_io_registers.sv
s3g_interrupt_ctrl.sv
s3g_response_builder.sv
s3g_executor.sv
tb_s3g_executor.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the executor testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_s3g_executor \
    -f verilog.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
